// File: common/exec_defs.svh
`ifndef EXEC_DEFS_SVH
`define EXEC_DEFS_SVH

// Data path width and architectural register count.
`define XLEN 64
`define NREG 32

// Major opcode values of the instruction groups handled by the execute slice.
`define OPC_OP        7'b0110011
`define OPC_OP_IMM    7'b0010011
`define OPC_OP_32     7'b0111011
`define OPC_OP_IMM_32 7'b0011011
`define OPC_BRANCH    7'b1100011
`define OPC_LUI       7'b0110111
`define OPC_AUIPC     7'b0010111

`endif

// File: common/exec_pkg.sv
`include "exec_defs.svh"

package exec_pkg;

  localparam int REG_AW = $clog2(`NREG);

  typedef struct packed {
    logic [6:0]        funct7;
    logic [REG_AW-1:0] rs2;
    logic [REG_AW-1:0] rs1;
    logic [2:0]        funct3;
    logic [REG_AW-1:0] rd;
    logic [6:0]        opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0]       imm12;
    logic [REG_AW-1:0] rs1;
    logic [2:0]        funct3;
    logic [REG_AW-1:0] rd;
    logic [6:0]        opcode;
  } i_fmt_t;

  // Branch immediate is scattered over the word, bit 0 is implied zero.
  typedef struct packed {
    logic              imm12;
    logic [5:0]        imm10_5;
    logic [REG_AW-1:0] rs2;
    logic [REG_AW-1:0] rs1;
    logic [2:0]        funct3;
    logic [3:0]        imm4_1;
    logic              imm11;
    logic [6:0]        opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0]       imm20;
    logic [REG_AW-1:0] rd;
    logic [6:0]        opcode;
  } u_fmt_t;

  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    b_fmt_t b;
    u_fmt_t u;
  } instr_u;

  typedef struct packed {
    logic              alu_en;
    logic [4:0]        alu_opcode;
    logic              alu_halfop;
    logic              branch_en;
    logic [2:0]        branch_opcode;
    logic              pc_en;
    logic              imm_en;
    logic              fw_en1;
    logic              fw_en2;
    logic [REG_AW-1:0] rs1;
    logic [REG_AW-1:0] rs2;
    logic [REG_AW-1:0] rd;
  } alu_ctrl_t;

  typedef struct packed {
    logic              valid;
    logic [REG_AW-1:0] rd;
    logic [`XLEN-1:0]  data;
  } ex_result_t;

endpackage

// File: alu/alu.sv
`timescale 1ns/1ns
`include "exec_defs.svh"

module alu import exec_pkg::*; (
  input  alu_ctrl_t        ctrl,
  input  logic [`XLEN-1:0] pc,
  input  logic [`XLEN-1:0] fw_data,
  input  logic [`XLEN-1:0] gpr_data1,
  input  logic [`XLEN-1:0] gpr_data2,
  input  logic [`XLEN-1:0] imm,
  output logic [`XLEN-1:0] alu_result,
  output logic             branch_result
);

  logic [63:0]  op1;
  logic [63:0]  op2;
  logic [3:0]   sel;
  logic         gpr_en1;
  logic         gpr_en2;
  logic [31:0]  wop1;
  logic [31:0]  wop2;

  assign sel = {ctrl.alu_opcode[4], ctrl.alu_opcode[2:0]};

  // PC wins over forwarding on the first operand, the immediate on the second.
  assign gpr_en1 = !ctrl.pc_en && !ctrl.fw_en1;
  assign gpr_en2 = !ctrl.imm_en && !ctrl.fw_en2;

  assign op1 = ({64{gpr_en1}} & gpr_data1) |
               ({64{ctrl.pc_en}} & pc) |
               ({64{ctrl.fw_en1 & !ctrl.pc_en}} & fw_data);

  assign op2 = ({64{gpr_en2}} & gpr_data2) |
               ({64{ctrl.imm_en}} & imm) |
               ({64{ctrl.fw_en2 & !ctrl.imm_en}} & fw_data);

  assign wop1 = op1[31:0];
  assign wop2 = op2[31:0];

  logic        opid_en;
  logic [63:0] opid_result;

  assign opid_en = ctrl.alu_en & !ctrl.alu_halfop & !ctrl.alu_opcode[3];

  assign opid_result =
    ({64{sel == 4'b0000}} & (op1 + op2)) |
    ({64{sel == 4'b1000}} & (op1 - op2)) |
    ({64{sel == 4'b0001}} & (op1 << op2[5:0])) |
    ({64{sel == 4'b0010}} & {63'b0, $signed(op1) < $signed(op2)}) |
    ({64{sel == 4'b0011}} & {63'b0, op1 < op2}) |
    ({64{sel == 4'b0100}} & (op1 ^ op2)) |
    ({64{sel == 4'b0101}} & (op1 >> op2[5:0])) |
    ({64{sel == 4'b1101}} & 64'($signed(op1) >>> op2[5:0])) |
    ({64{sel == 4'b0110}} & (op1 | op2)) |
    ({64{sel == 4'b0111}} & (op1 & op2));

  logic         opmd_en;
  logic [127:0] mul_ss;
  logic [127:0] mul_su;
  logic [127:0] mul_uu;
  logic [63:0]  opmd_result;

  assign opmd_en = ctrl.alu_en & !ctrl.alu_halfop & ctrl.alu_opcode[3];

  // Operands are widened to 128 bits, by sign for a signed operand and by zeros otherwise.
  assign mul_ss = {{64{op1[63]}}, op1} * {{64{op2[63]}}, op2};
  assign mul_su = {{64{op1[63]}}, op1} * {64'b0, op2};
  assign mul_uu = {64'b0, op1} * {64'b0, op2};

  assign opmd_result =
    ({64{sel == 4'b0000}} & mul_ss[63:0]) |
    ({64{sel == 4'b0001}} & mul_ss[127:64]) |
    ({64{sel == 4'b0010}} & mul_su[127:64]) |
    ({64{sel == 4'b0011}} & mul_uu[127:64]) |
    ({64{sel == 4'b0100}} & 64'($signed(op1) / $signed(op2))) |
    ({64{sel == 4'b0101}} & (op1 / op2)) |
    ({64{sel == 4'b0110}} & 64'($signed(op1) % $signed(op2))) |
    ({64{sel == 4'b0111}} & (op1 % op2));

  logic        opiw_en;
  logic [31:0] opiw_result;

  assign opiw_en = ctrl.alu_en & ctrl.alu_halfop & !ctrl.alu_opcode[3];

  assign opiw_result =
    ({32{sel == 4'b0000}} & (wop1 + wop2)) |
    ({32{sel == 4'b1000}} & (wop1 - wop2)) |
    ({32{sel == 4'b0001}} & (wop1 << wop2[4:0])) |
    ({32{sel == 4'b0101}} & (wop1 >> wop2[4:0])) |
    ({32{sel == 4'b1101}} & 32'($signed(wop1) >>> wop2[4:0]));

  logic        opmw_en;
  logic [31:0] opmw_result;

  assign opmw_en = ctrl.alu_en & ctrl.alu_halfop & ctrl.alu_opcode[3];

  assign opmw_result =
    ({32{sel == 4'b0000}} & (wop1 * wop2)) |
    ({32{sel == 4'b0100}} & 32'($signed(wop1) / $signed(wop2))) |
    ({32{sel == 4'b0101}} & (wop1 / wop2)) |
    ({32{sel == 4'b0110}} & 32'($signed(wop1) % $signed(wop2))) |
    ({32{sel == 4'b0111}} & (wop1 % wop2));

  // Word results are sign-extended from bit 31.
  assign alu_result = ({64{opid_en}} & opid_result) |
                      ({64{opmd_en}} & opmd_result) |
                      ({64{opiw_en}} & {{32{opiw_result[31]}}, opiw_result}) |
                      ({64{opmw_en}} & {{32{opmw_result[31]}}, opmw_result});

  assign branch_result = ctrl.branch_en & (
    ((ctrl.branch_opcode == 3'b000) & (op1 == op2)) |
    ((ctrl.branch_opcode == 3'b001) & (op1 != op2)) |
    ((ctrl.branch_opcode == 3'b100) & ($signed(op1) < $signed(op2))) |
    ((ctrl.branch_opcode == 3'b101) & ($signed(op1) >= $signed(op2))) |
    ((ctrl.branch_opcode == 3'b110) & (op1 < op2)) |
    ((ctrl.branch_opcode == 3'b111) & (op1 >= op2)));

endmodule

// File: source/exec_ctrl.sv
`timescale 1ns/1ns
`include "exec_defs.svh"

module exec_ctrl import exec_pkg::*; (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             instr_valid,
  input  instr_u           instr,
  input  logic [`XLEN-1:0] alu_result,
  input  logic             branch_result,
  output alu_ctrl_t        ctrl,
  output ex_result_t       ex_res,
  output logic             br_valid,
  output logic             br_taken
);

  logic [6:0]        opcode;
  logic              is_op;
  logic              is_op_imm;
  logic              is_op_32;
  logic              is_op_imm_32;
  logic              is_branch;
  logic              is_lui;
  logic              is_auipc;
  logic              reg_form;
  logic              imm_form;
  logic              alt_bit;
  logic [REG_AW-1:0] rs1_idx;
  logic [REG_AW-1:0] rs2_idx;

  assign opcode       = instr.r.opcode;
  assign is_op        = (opcode == `OPC_OP);
  assign is_op_imm    = (opcode == `OPC_OP_IMM);
  assign is_op_32     = (opcode == `OPC_OP_32);
  assign is_op_imm_32 = (opcode == `OPC_OP_IMM_32);
  assign is_branch    = (opcode == `OPC_BRANCH);
  assign is_lui       = (opcode == `OPC_LUI);
  assign is_auipc     = (opcode == `OPC_AUIPC);

  assign reg_form = is_op | is_op_32;
  assign imm_form = is_op_imm | is_op_imm_32;

  // Bit 30 selects SUB and SRA. In immediate forms it is only an opcode bit for
  // right shifts, elsewhere it belongs to the immediate.
  assign alt_bit = instr.r.funct7[5] & (reg_form | (instr.r.funct3 == 3'b101));

  // LUI reads x0, so both source indices are forced to zero outside their formats.
  assign rs1_idx = (reg_form | imm_form | is_branch) ? instr.r.rs1 : '0;
  assign rs2_idx = (reg_form | is_branch) ? instr.r.rs2 : '0;

  always_comb begin
    ctrl               = '0;
    ctrl.alu_en        = reg_form | imm_form | is_lui | is_auipc;
    ctrl.alu_halfop    = is_op_32 | is_op_imm_32;
    ctrl.branch_en     = is_branch;
    ctrl.branch_opcode = instr.b.funct3;
    ctrl.pc_en         = is_auipc;
    ctrl.imm_en        = imm_form | is_lui | is_auipc;
    ctrl.rs1           = rs1_idx;
    ctrl.rs2           = rs2_idx;
    ctrl.rd            = ctrl.alu_en ? instr.r.rd : '0;
    ctrl.fw_en1        = ex_res.valid & (rs1_idx == ex_res.rd) & (ex_res.rd != '0);
    ctrl.fw_en2        = ex_res.valid & (rs2_idx == ex_res.rd) & (ex_res.rd != '0);
    if (reg_form | imm_form) begin
      ctrl.alu_opcode = {alt_bit, reg_form & instr.r.funct7[0], instr.r.funct3};
    end
  end

  always_ff @(posedge clk) begin
    ex_res.rd   <= ctrl.rd;
    ex_res.data <= alu_result;
    if (!rst_n) begin
      ex_res.valid <= 1'b0;
      br_valid     <= 1'b0;
      br_taken     <= 1'b0;
    end else begin
      ex_res.valid <= instr_valid & ctrl.alu_en;
      br_valid     <= instr_valid & ctrl.branch_en;
      br_taken     <= instr_valid & branch_result;
    end
  end

endmodule

// File: source/regfile.sv
`timescale 1ns/1ns
`include "exec_defs.svh"

module regfile import exec_pkg::*; (
  input  logic              clk,
  input  logic              rst_n,
  input  logic [REG_AW-1:0] rs1,
  input  logic [REG_AW-1:0] rs2,
  input  ex_result_t        wr,
  output logic [`XLEN-1:0]  gpr_data1,
  output logic [`XLEN-1:0]  gpr_data2
);

  // x0 has no storage.
  logic [`XLEN-1:0] gpr [1:`NREG-1];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 1; i < `NREG; i++) begin
        gpr[i] <= '0;
      end
    end else if (wr.valid && (wr.rd != '0)) begin
      gpr[wr.rd] <= wr.data;
    end
  end

  assign gpr_data1 = (rs1 == '0) ? '0 : gpr[rs1];
  assign gpr_data2 = (rs2 == '0) ? '0 : gpr[rs2];

endmodule

// File: source/imm_gen.sv
`timescale 1ns/1ns
`include "exec_defs.svh"

module imm_gen import exec_pkg::*; (
  input  instr_u           instr,
  output logic [`XLEN-1:0] imm
);

  always_comb begin
    case (instr.r.opcode)
      // Shift immediates come out as is, the ALU only looks at the shamt bits.
      `OPC_OP_IMM, `OPC_OP_IMM_32: begin
        imm = {{(`XLEN-12){instr.i.imm12[11]}}, instr.i.imm12};
      end
      `OPC_BRANCH: begin
        imm = {{(`XLEN-12){instr.b.imm12}}, instr.b.imm11, instr.b.imm10_5,
               instr.b.imm4_1, 1'b0};
      end
      `OPC_LUI, `OPC_AUIPC: begin
        imm = {{(`XLEN-32){instr.u.imm20[19]}}, instr.u.imm20, 12'b0};
      end
      default: begin
        imm = '0;
      end
    endcase
  end

endmodule

// File: source/exec_top.sv
`timescale 1ns/1ns
`include "exec_defs.svh"

module exec_top import exec_pkg::*; (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              instr_valid,
  input  logic [31:0]       instr,
  input  logic [`XLEN-1:0]  pc,
  output logic              wb_valid,
  output logic [REG_AW-1:0] wb_rd,
  output logic [`XLEN-1:0]  wb_data,
  output logic              br_valid,
  output logic              br_taken
);

  instr_u           instr_w;
  alu_ctrl_t        ctrl;
  ex_result_t       ex_res;
  logic [`XLEN-1:0] gpr_data1;
  logic [`XLEN-1:0] gpr_data2;
  logic [`XLEN-1:0] imm;
  logic [`XLEN-1:0] alu_result;
  logic             branch_result;

  assign instr_w = instr;

  exec_ctrl u_exec_ctrl (
    .clk           (clk),
    .rst_n         (rst_n),
    .instr_valid   (instr_valid),
    .instr         (instr_w),
    .alu_result    (alu_result),
    .branch_result (branch_result),
    .ctrl          (ctrl),
    .ex_res        (ex_res),
    .br_valid      (br_valid),
    .br_taken      (br_taken)
  );

  regfile u_regfile (
    .clk       (clk),
    .rst_n     (rst_n),
    .rs1       (ctrl.rs1),
    .rs2       (ctrl.rs2),
    .wr        (ex_res),
    .gpr_data1 (gpr_data1),
    .gpr_data2 (gpr_data2)
  );

  imm_gen u_imm_gen (
    .instr (instr_w),
    .imm   (imm)
  );

  // The only forwarding source is the result register.
  alu u_alu (
    .ctrl          (ctrl),
    .pc            (pc),
    .fw_data       (ex_res.data),
    .gpr_data1     (gpr_data1),
    .gpr_data2     (gpr_data2),
    .imm           (imm),
    .alu_result    (alu_result),
    .branch_result (branch_result)
  );

  assign wb_valid = ex_res.valid;
  assign wb_rd    = ex_res.rd;
  assign wb_data  = ex_res.data;

endmodule

// File: verification/exec_tb.sv
`timescale 1ns/1ns
`include "exec_defs.svh"

module exec_tb;

  localparam int RESET_LIMIT  = 40;
  localparam int DRAIN_LIMIT  = 8;
  localparam int KIND_WB      = 1;
  localparam int KIND_BRANCH  = 2;

  // ADDI x1, x0, 100 and BEQ x1, x1 presented while the strobe is low.
  localparam logic [31:0] IDLE_ALU    = 32'h06400093;
  localparam logic [31:0] IDLE_BRANCH = 32'h00108463;

  logic             clk = 1'b0;
  logic             rst_n;
  logic             instr_valid;
  logic [31:0]      instr;
  logic [`XLEN-1:0] pc;
  logic             wb_valid;
  logic [4:0]       wb_rd;
  logic [`XLEN-1:0] wb_data;
  logic             br_valid;
  logic             br_taken;

  int fd;

  exec_top dut0 (
    .clk         (clk),
    .rst_n       (rst_n),
    .instr_valid (instr_valid),
    .instr       (instr),
    .pc          (pc),
    .wb_valid    (wb_valid),
    .wb_rd       (wb_rd),
    .wb_data     (wb_data),
    .br_valid    (br_valid),
    .br_taken    (br_taken)
  );

  always #50 clk = ~clk;

  initial begin : reset_gen
    rst_n <= 1'b0;
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
  end

  task automatic fail_run();
    $display("Done: errors found");
    $fatal(1, "Simulation stopped");
  endtask

  task automatic check_val(input string name, input logic [63:0] expected,
                           input logic [63:0] actual);
    if (actual !== expected) begin
      $display("** Error %s: expected %h, actual %h", name, expected, actual);
      fail_run();
    end
  endtask

  // Compares the outputs against one stimulus line that the DUT took on the last edge.
  task automatic compare_outputs(input string name, input logic [31:0] ins, input int kind,
                                 input logic [63:0] data, input int taken);
    if (kind == KIND_WB) begin
      check_val({name, " wb_valid"}, 64'd1, 64'(wb_valid));
      check_val({name, " wb_rd"}, 64'(ins[11:7]), 64'(wb_rd));
      check_val({name, " wb_data"}, data, wb_data);
    end else begin
      check_val({name, " wb_valid"}, 64'd0, 64'(wb_valid));
    end
    check_val({name, " br_valid"}, (kind == KIND_BRANCH) ? 64'd1 : 64'd0, 64'(br_valid));
    check_val({name, " br_taken"}, 64'(taken), 64'(br_taken));
  endtask

  task automatic skip_line();
    int c;
    c = $fgetc(fd);
    while (c != 10 && c != -1) begin
      c = $fgetc(fd);
    end
  endtask

  initial begin : main
    string       name;
    string       prev_name;
    logic [31:0] v_instr;
    logic [31:0] prev_instr;
    logic [63:0] v_pc;
    logic [63:0] v_data;
    logic [63:0] prev_data;
    int          v_kind;
    int          prev_kind;
    int          v_taken;
    int          prev_taken;
    int          code;
    int          cycles;
    bit          have_prev;
    bit          done;

    instr_valid <= 1'b0;
    instr       <= '0;
    pc          <= '0;
    have_prev = 1'b0;
    done      = 1'b0;

    fd = $fopen("verification/exec_stimulus.txt", "r");
    if (fd == 0) begin
      $display("Could not open the stimulus file verification/exec_stimulus.txt");
      fail_run();
    end

    // Nothing may come out while reset is held.
    cycles = 0;
    while (rst_n !== 1'b1) begin
      @(negedge clk);
      check_val("reset wb_valid", 64'd0, 64'(wb_valid));
      check_val("reset br_valid", 64'd0, 64'(br_valid));
      cycles++;
      if (cycles > RESET_LIMIT) begin
        $display("Reset was still asserted after %0d cycles", RESET_LIMIT);
        fail_run();
      end
    end

    // One instruction per cycle, so each line is checked while the next one is in flight.
    while (!done) begin
      code = $fscanf(fd, "%s", name);
      if (code != 1) begin
        done = 1'b1;
      end else if (name[0] == 8'h23) begin
        skip_line();
      end else begin
        code = $fscanf(fd, "%h %h %d %h %d", v_instr, v_pc, v_kind, v_data, v_taken);
        if (code != 5) begin
          $display("Stimulus line %s is not in the expected format", name);
          fail_run();
        end
        @(posedge clk);
        instr_valid <= 1'b1;
        instr       <= v_instr;
        pc          <= v_pc;
        @(negedge clk);
        if (have_prev) begin
          compare_outputs(prev_name, prev_instr, prev_kind, prev_data, prev_taken);
        end
        prev_name  = name;
        prev_instr = v_instr;
        prev_kind  = v_kind;
        prev_data  = v_data;
        prev_taken = v_taken;
        have_prev  = 1'b1;
      end
    end
    $fclose(fd);

    @(posedge clk);
    instr_valid <= 1'b0;
    instr       <= '0;
    pc          <= '0;
    @(negedge clk);
    if (have_prev) begin
      compare_outputs(prev_name, prev_instr, prev_kind, prev_data, prev_taken);
    end

    cycles = 0;
    @(negedge clk);
    while (wb_valid !== 1'b0 || br_valid !== 1'b0) begin
      cycles++;
      if (cycles > DRAIN_LIMIT) begin
        $display("Outputs stayed valid for %0d cycles after the input went idle", cycles);
        fail_run();
      end
      @(negedge clk);
    end

    // A decodable instruction without the strobe must not produce any output.
    for (int i = 0; i < 4; i++) begin
      @(posedge clk);
      instr <= (i % 2 == 0) ? IDLE_ALU : IDLE_BRANCH;
      @(negedge clk);
      check_val("idle wb_valid", 64'd0, 64'(wb_valid));
      check_val("idle br_valid", 64'd0, 64'(br_valid));
    end

    $display("Done: no errors");
    $finish;
  end

endmodule

// File: verification/exec_stimulus.txt
# name instr pc kind expected_wb_data expected_br_taken
# instr, pc and wb_data in hex; kind 0 = no output, 1 = write-back, 2 = branch
first_read   007302B3 1000 1 0 0
addi_x1      06400093 1004 1 64 0
addi_x2      FF900113 1008 1 FFFFFFFFFFFFFFF9 0
lui_x3       123451B7 100C 1 12345000 0
addi_fwd     67818193 1010 1 12345678 0
slli_32      02019213 1014 1 1234567800000000 0
or_fwd       00326233 1018 1 1234567812345678 0
add          00208533 101C 1 5D 0
sub          401105B3 1020 1 FFFFFFFFFFFFFF95 0
sll_57       00209633 1024 1 C800000000000000 0
slt          001126B3 1028 1 1 0
sltu         00113733 102C 1 0 0
xor          002247B3 1030 1 EDCBA987EDCBA981 0
srl_fwd      0017D833 1034 1 EDCBA98 0
sra          4017D8B3 1038 1 FFFFFFFFFEDCBA98 0
and_fwd      0048F933 103C 1 1234567812141218 0
mul          02208A33 1040 1 FFFFFFFFFFFFFD44 0
mulh         02C21AB3 1044 1 FC048D15BC048D15 0
mulhsu       02C12BB3 1048 1 FFFFFFFFFFFFFFFA 0
mulhu        02C23B33 104C 1 0E38E38DCE38E38D 0
div          0225CC33 1050 1 F 0
divu         02165CB3 1054 1 0200000000000000 0
rem          0225ED33 1058 1 FFFFFFFFFFFFFFFE 0
remu         02117DB3 105C 1 9 0
addw         00F202BB 1060 1 FFFFFFFFFFFFFFF9 0
subw         4040833B 1064 1 FFFFFFFFEDCBA9EC 0
sllw         002193BB 1068 1 FFFFFFFFF0000000 0
srlw         0017D43B 106C 1 EDCBA98 0
sraw         4017D4BB 1070 1 FFFFFFFFFEDCBA98 0
mulw         022189BB 1074 1 FFFFFFFF8091A2B8 0
divw         0217CE3B 1078 1 FFFFFFFFFFD16589 0
remw         0217EEBB 107C 1 FFFFFFFFFFFFFFFD 0
divuw        0217DF3B 1080 1 260C1B1 0
remuw        0217FFBB 1084 1 5D 0
beq_equal    00108463 1088 2 0 1
bne_equal    00109463 108C 2 0 0
blt_neg      00114463 1090 2 0 1
bge_neg      00115463 1094 2 0 0
bltu_large   00116463 1098 2 0 0
bgeu_large   00117463 109C 2 0 1
addi_x5      06400293 10A0 1 64 0
beq_fwd      00128463 10A4 2 0 1
addi_x9      00500493 10A8 1 5 0
sub_fwd_rs2  409084B3 10AC 1 5F 0
add_fwd_both 009484B3 10B0 1 BE 0
auipc_pos    00001597 80001000 1 80002000 0
auipc_neg    FFFFF597 80001000 1 80000000 0
lui_neg      FFFFF6B7 10BC 1 FFFFFFFFFFFFF000 0
addi_x0      03700013 10C0 1 37 0
add_x0_read  00000733 10C4 1 0 0
bubble       00000000 10C8 0 0 0

// File: files.f
+incdir+common
common/exec_pkg.sv
alu/alu.sv
source/exec_ctrl.sv
source/regfile.sv
source/imm_gen.sv
source/exec_top.sv
verification/exec_tb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" \
  && verilator --binary -f files.f --top-module exec_tb -o exec_sim \
  && ./obj_dir/exec_sim | tee /dev/stderr | grep -q "Done: no errors" \
  || { echo "Simulation did not pass"; exit 1; }
